//--- verif/colmix_stimulus.txt
# W or R: table (c color, m shade), address, write data or expected rdata, all hex
# P: mode ord oow oowc hbl_n vbl_n neg s1col s1idx s2col s2idx ocol oidx oprio red green blue
W c 8F 0A5C
W c 05 0123
W c 4A 0456
W c 91 07E1
W c 96 0F0F
W c C0 09AB
W c F4 03C7
W c 33 F456
W m 06 FFA9
W m 18 0003
R c 8F 0A5C
R c 33 0456
R m 06 0009
R m 18 0003
P 0 0 0 0 1 1 0 1 1 2 2 3 3 3 C 5 A
P 0 0 0 0 1 1 0 1 1 2 2 4 1 2 3 2 1
P 0 1 0 0 1 1 0 1 1 2 2 4 1 2 6 5 4
P 0 0 0 0 1 1 0 1 0 2 2 4 1 2 1 E 7
P 0 0 0 0 1 1 0 1 0 2 2 5 2 1 6 5 4
P 0 0 0 0 1 1 0 1 0 2 0 5 2 1 F 0 F
P 0 0 0 0 1 1 0 1 0 2 0 3 3 0 B A 9
P 0 0 1 5 1 1 0 1 1 2 2 3 3 3 7 C 3
P 1 0 0 0 1 1 0 3 2 2 0 0 0 0 9 9 9
P 1 0 0 0 1 1 0 3 0 2 0 0 0 0 3 3 3
P 1 0 0 0 1 1 1 3 2 2 0 0 0 0 6 6 6
P 0 0 0 0 1 1 1 1 1 2 2 3 3 3 3 A 5
P 0 0 0 0 0 1 1 1 1 2 2 3 3 3 0 0 0
P 0 0 0 0 1 0 0 1 1 2 2 3 3 3 0 0 0

//--- files.f
rtl/lcd_pxl_pkg.sv
rtl/pal_bus_pkg.sv
rtl/layer_prio.sv
rtl/pal_ram.sv
rtl/pal_bank.sv
rtl/lcd_out.sv
rtl/ngp_colmix.sv
verif/colmix_props.sv
verif/colmix_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the color mixer testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/100ps --top-module colmix_tb \
    -f files.f -o colmix_sim || { echo "build failed"; exit 1; }
./obj_dir/colmix_sim +verilator+error+limit+100 | tee /dev/stderr \
    | grep -q "Simulation finished: PASS" && echo "run passed" && exit 0
echo "run failed"
exit 1

//--- verif/colmix_tb.sv
/* color mixer testbench */
`default_nettype none

module colmix_tb import lcd_pxl_pkg::*, pal_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int STROBE_TIMEOUT = 16;    // clocks, strobe comes every 4

    logic              clk = 1'b0;
    logic              rst_n;
    logic              pxl_cen = 1'b0;
    logic [1:0]        cen_cnt = 2'd0;
    logic              mode, scr_order, oow, hbl_n, vbl_n, lcd_neg;
    logic [2:0]        oowc;
    lyr_pxl_t          scr1, scr2;
    obj_pxl_t          obj;
    cpu_pal_t          cpu;
    logic [CPU_DW-1:0] rdata;
    logic [3:0]        red, green, blue;
    int                fld [17];           // fields of the current data line
    int                checks = 0;
    int                errors = 0;
    int                timeouts = 0;

    always #50 clk = ~clk;

    // one clock pixel strobe every 4 clocks
    always @(negedge clk) begin
        if (!rst_n) begin
            cen_cnt <= 2'd0;
            pxl_cen <= 1'b0;
        end else begin
            cen_cnt <= cen_cnt + 2'd1;
            pxl_cen <= cen_cnt == 2'd3;
        end
    end

    ngp_colmix #(.COL_AW(COL_AW), .MONO_AW(MONO_AW)) DUT (.*);

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = DUT.u_out.props_out.fail_cnt + DUT.u_bank.props_bank.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d",
                 checks, errors, prop_fails, timeouts);
        if (errors == 0 && prop_fails == 0 && timeouts == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    // returns just after the rising edge that carries pxl_cen
    task automatic wait_strobe(output logic seen);
        int n;
        n = 0;
        @(posedge clk);
        while (!pxl_cen && n < STROBE_TIMEOUT) begin
            n++;
            @(posedge clk);
        end
        seen = pxl_cen;
        if (!seen) begin
            timeouts++;
            $display("pixel strobe never came within %0d clocks", STROBE_TIMEOUT);
        end
    endtask

    task automatic cpu_write(input logic col, input logic [7:0] addr, input logic [15:0] data);
        @(negedge clk);
        cpu = '{addr: addr, wdata: data, we: 1'b1, col_cs: col, mono_cs: !col};
        @(negedge clk);
        cpu = '0;
    endtask

    task automatic cpu_read(input logic col, input logic [7:0] addr, input logic [15:0] exp);
        @(negedge clk);
        cpu = '{addr: addr, wdata: '0, we: 1'b0, col_cs: col, mono_cs: !col};
        @(negedge clk);
        check_val("rdata", rdata, exp);     // valid from the edge after the read
        cpu = '0;
    endtask

    task automatic run_pixel(output logic seen);
        @(negedge clk);
        mode      = fld[0][0];
        scr_order = fld[1][0];
        oow       = fld[2][0];
        oowc      = fld[3][2:0];
        hbl_n     = fld[4][0];
        vbl_n     = fld[5][0];
        lcd_neg   = fld[6][0];     // used at the output strobe
        scr1      = '{col: fld[7][3:0], idx: fld[8][1:0]};
        scr2      = '{col: fld[9][3:0], idx: fld[10][1:0]};
        obj       = '{pxl: '{col: fld[11][3:0], idx: fld[12][1:0]}, prio: fld[13][1:0]};
        wait_strobe(seen);         // pixel sampled here
        if (seen) begin
            @(negedge clk);
            hbl_n = 1'b0;          // next pixel blanked
            vbl_n = 1'b0;
            wait_strobe(seen);     // colors registered here
        end
        if (seen) begin
            @(negedge clk);
            check_val("red", {12'h0, red}, fld[14][15:0]);
            check_val("green", {12'h0, green}, fld[15][15:0]);
            check_val("blue", {12'h0, blue}, fld[16][15:0]);
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    c;
        string op;
        string tbl;
        logic  done;
        logic  strobe_ok;
        rst_n     = 1'b0;
        mode      = 1'b0;
        scr_order = 1'b0;
        oow       = 1'b0;
        oowc      = 3'd0;
        hbl_n     = 1'b1;
        vbl_n     = 1'b1;
        lcd_neg   = 1'b0;
        scr1      = '0;
        scr2      = '0;
        obj       = '0;
        cpu       = '0;
        done      = 1'b0;
        strobe_ok = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        fd = $fopen("verif/colmix_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stimulus file verif/colmix_stimulus.txt");
            finish_run();
        end else begin
            while (!done) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    done = 1'b1;                // end of file
                end else if (op == "#") begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (op == "W" || op == "R") begin
                    code = $fscanf(fd, "%s %h %h", tbl, fld[0], fld[1]);
                    if (code != 3) begin
                        errors++;
                        $display("access line in the stimulus file has too few fields");
                        done = 1'b1;
                    end else if (op == "W") begin
                        cpu_write(tbl == "c", fld[0][7:0], fld[1][15:0]);
                    end else begin
                        cpu_read(tbl == "c", fld[0][7:0], fld[1][15:0]);
                    end
                end else if (op == "P") begin
                    code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                   fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                   fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                                   fld[12], fld[13], fld[14], fld[15], fld[16]);
                    if (code != 17) begin
                        errors++;
                        $display("pixel line in the stimulus file has too few fields");
                        done = 1'b1;
                    end else begin
                        run_pixel(strobe_ok);
                        if (!strobe_ok) begin
                            done = 1'b1;        // no strobe, stop reading
                        end
                    end
                end else begin
                    errors++;
                    $display("unknown opcode %s in the stimulus file", op);
                    done = 1'b1;
                end
            end
            $fclose(fd);
            finish_run();
        end
    end

endmodule

`default_nettype wire

//--- verif/colmix_props.sv
/* mixer assertions */
`default_nettype none

module colmix_props (
    input logic        clk,
    input logic        rst_n,
    input logic        pxl_cen,
    input logic        blank,
    input logic [11:0] pix,      // red, green, blue
    input logic        rd,
    input logic [15:0] rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;            // read by the testbench

    // blanked pixel registers as black
    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen && blank |=> pix == '0)
        else begin
            fail_cnt++;
            $error("pixel not black while blanked");
        end

    reset_zero: assert property (@(posedge clk) !rst_n |=> pix == '0 && rdata == '0)
        else begin
            fail_cnt++;
            $error("outputs not zero after reset");
        end

    // no read last cycle, rdata holds
    rdata_hold: assert property (@(posedge clk) disable iff (!rst_n) !rd |=> $stable(rdata))
        else begin
            fail_cnt++;
            $error("rdata changed without a read");
        end

endmodule

bind lcd_out colmix_props props_out (
    .clk     (clk),
    .rst_n   (rst_n),
    .pxl_cen (pxl_cen),
    .blank   (mix.blank),
    .pix     ({red, green, blue}),
    .rd      (1'b0),
    .rdata   (16'h0000)
);

bind pal_bank colmix_props props_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .pxl_cen (1'b0),
    .blank   (1'b0),
    .pix     (12'h000),
    .rd      (rd),
    .rdata   (rdata)
);

`default_nettype wire

//--- rtl/ngp_colmix.sv
/* color mixer top */
`default_nettype none

module ngp_colmix import lcd_pxl_pkg::*, pal_bus_pkg::*; #(
    parameter int COL_AW  = pal_bus_pkg::COL_AW,
    parameter int MONO_AW = pal_bus_pkg::MONO_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pxl_cen,     // one clock pixel strobe
    input  logic              mode,        // 1 is monochrome
    input  logic              scr_order,
    input  logic              oow,
    input  logic [2:0]        oowc,
    input  logic              hbl_n,
    input  logic              vbl_n,
    input  logic              lcd_neg,
    input  lyr_pxl_t          scr1,
    input  lyr_pxl_t          scr2,
    input  obj_pxl_t          obj,
    input  cpu_pal_t          cpu,
    output logic [CPU_DW-1:0] rdata,
    output logic [3:0]        red,
    output logic [3:0]        green,
    output logic [3:0]        blue
);

    mix_pxl_t mix;
    rgb_t     col_q;
    shade_t   shade_q;

    // sampled at pxl_cen n
    layer_prio u_prio (
        .clk       (clk),
        .rst_n     (rst_n),
        .pxl_cen   (pxl_cen),
        .mode      (mode),
        .scr_order (scr_order),
        .oow       (oow),
        .oowc      (oowc),
        .hbl_n     (hbl_n),
        .vbl_n     (vbl_n),
        .scr1      (scr1),
        .scr2      (scr2),
        .obj       (obj),
        .mix       (mix)
    );

    // palette data one clock after mix
    pal_bank #(.COL_AW(COL_AW), .MONO_AW(MONO_AW)) u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .cpu     (cpu),
        .rdata   (rdata),
        .mix     (mix),
        .col_q   (col_q),
        .shade_q (shade_q)
    );

    // colors out at pxl_cen n+1
    lcd_out u_out (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .lcd_neg (lcd_neg),
        .mix     (mix),
        .col_q   (col_q),
        .shade_q (shade_q),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

endmodule

`default_nettype wire

//--- rtl/lcd_out.sv
/* LCD output stage */
`default_nettype none

module lcd_out import lcd_pxl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       pxl_cen,
    input  logic       lcd_neg,
    input  mix_pxl_t   mix,
    input  rgb_t       col_q,
    input  shade_t     shade_q,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    rgb_t pal, neg, pix;

    // grey from the shade table in mono mode
    always_comb begin
        if (mix.mono) begin
            pal = '{b: shade_q, g: shade_q, r: shade_q};
        end else begin
            pal = col_q;
        end
    end

    always_comb begin
        neg.r = 4'hf - pal.r;
        neg.g = 4'hf - pal.g;
        neg.b = 4'hf - pal.b;
        pix   = lcd_neg ? neg : pal;
        if (mix.blank) begin
            pix = '0;           // black outside active area
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            red   <= 4'h0;
            green <= 4'h0;
            blue  <= 4'h0;
        end else if (pxl_cen) begin
            red   <= pix.r;
            green <= pix.g;
            blue  <= pix.b;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pal_bank.sv
/* palette bank */
`default_nettype none

module pal_bank import lcd_pxl_pkg::*, pal_bus_pkg::*; #(
    parameter int COL_AW  = pal_bus_pkg::COL_AW,
    parameter int MONO_AW = pal_bus_pkg::MONO_AW
) (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pal_t          cpu,
    output logic [CPU_DW-1:0] rdata,
    input  mix_pxl_t          mix,
    output rgb_t              col_q,
    output shade_t            shade_q
);

    logic              col_we, mono_we;
    logic              rd, rd_q, rd_col_q;
    rgb_t              cpu_col;
    shade_t            cpu_shade;
    logic [CPU_DW-1:0] rd_mux, hold_q;

    assign col_we  = cpu.we & cpu.col_cs;
    assign mono_we = cpu.we & cpu.mono_cs;
    assign rd      = ~cpu.we & (cpu.col_cs | cpu.mono_cs);

    pal_ram #(.AW(COL_AW), .entry_t(rgb_t)) u_col (
        .clk     (clk),
        .we      (col_we),
        .waddr   (COL_AW'(cpu.addr)),
        .wdata   (rgb_t'(cpu.wdata[11:0])),  // top nibble dropped
        .raddr_a (COL_AW'(cpu.addr)),
        .q_a     (cpu_col),
        .raddr_b (COL_AW'(mix.addr)),
        .q_b     (col_q)
    );

    pal_ram #(.AW(MONO_AW), .entry_t(shade_t)) u_mono (
        .clk     (clk),
        .we      (mono_we),
        .waddr   (MONO_AW'(cpu.addr)),
        .wdata   (shade_t'(cpu.wdata[3:0])),
        .raddr_a (MONO_AW'(cpu.addr)),
        .q_a     (cpu_shade),
        .raddr_b (MONO_AW'(mix.mono_addr)),
        .q_b     (shade_q)
    );

    // remember which table the read went to
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q     <= 1'b0;
            rd_col_q <= 1'b0;
            hold_q   <= '0;
        end else begin
            rd_q     <= rd;
            rd_col_q <= rd ? cpu.col_cs : rd_col_q;  // color wins if both
            hold_q   <= rdata;
        end
    end

    assign rd_mux = rd_col_q ? {4'h0, cpu_col} : {12'h0, cpu_shade};
    assign rdata  = rd_q ? rd_mux : hold_q;   // held between reads

endmodule

`default_nettype wire

//--- rtl/pal_ram.sv
/* dual read palette memory */
`default_nettype none

module pal_ram #(
    parameter int  AW      = 8,
    parameter type entry_t = logic [11:0]
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  entry_t        wdata,
    input  logic [AW-1:0] raddr_a,   // CPU side
    output entry_t        q_a,
    input  logic [AW-1:0] raddr_b,   // pixel side
    output entry_t        q_b
);

    entry_t mem [2**AW];

    // single write port, CPU only
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads registered, old data on collision
    always_ff @(posedge clk) begin
        q_a <= mem[raddr_a];
        q_b <= mem[raddr_b];
    end

endmodule

`default_nettype wire

//--- rtl/layer_prio.sv
/* layer priority and palette address */
`default_nettype none

module layer_prio import lcd_pxl_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     pxl_cen,
    input  logic     mode,
    input  logic     scr_order,
    input  logic     oow,       // outside of window
    input  logic [2:0] oowc,
    input  logic     hbl_n,
    input  logic     vbl_n,
    input  lyr_pxl_t scr1,
    input  lyr_pxl_t scr2,
    input  obj_pxl_t obj,
    output mix_pxl_t mix
);

    lyr_pxl_t front, rear;      // scrolls after ordering
    lyr_e     front_l, rear_l;
    lyr_pxl_t sel;              // winning pixel
    lyr_e     sel_l;
    logic     obj_op;

    assign obj_op = obj.pxl.idx != 2'd0;

    // scr_order set puts scroll 2 in front
    always_comb begin
        if (scr_order) begin
            front   = scr2;
            front_l = LYR_SCR2;
            rear    = scr1;
            rear_l  = LYR_SCR1;
        end else begin
            front   = scr1;
            front_l = LYR_SCR1;
            rear    = scr2;
            rear_l  = LYR_SCR2;
        end
    end

    always_comb begin
        sel_l = LYR_BACK;       // default is background at C0
        sel   = '0;
        if (oow) begin
            sel.col = {1'b1, oowc}; // window color, 8+oowc
        end else if (obj_op && obj.prio == 2'd3) begin
            sel_l = LYR_OBJ;
            sel   = obj.pxl;
        end else if (front.idx != 2'd0) begin
            sel_l = front_l;
            sel   = front;
        end else if (obj_op && obj.prio == 2'd2) begin
            sel_l = LYR_OBJ;
            sel   = obj.pxl;
        end else if (rear.idx != 2'd0) begin
            sel_l = rear_l;
            sel   = rear;
        end else if (obj_op && obj.prio == 2'd1) begin
            sel_l = LYR_OBJ;
            sel   = obj.pxl;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mix <= '{addr: '0, mono_addr: '0, mono: 1'b0, blank: 1'b1};
        end else if (pxl_cen) begin
            mix.addr      <= {sel_l, sel.col, sel.idx};
            mix.mono_addr <= {sel_l, sel.col[0], sel.idx};  // only one palette bit
            mix.mono      <= mode;
            mix.blank     <= ~hbl_n | ~vbl_n;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pal_bus_pkg.sv
/* CPU palette access */
`default_nettype none

package pal_bus_pkg;

    parameter int COL_AW  = 8;     // 256 color entries
    parameter int MONO_AW = 5;     // 32 shade entries
    parameter int CPU_DW  = 16;    // whole words only

    // one CPU access, selects are plain chip selects
    typedef struct packed {
        logic [7:0]        addr;
        logic [CPU_DW-1:0] wdata;
        logic              we;
        logic              col_cs;  // color table
        logic              mono_cs; // shade table
    } cpu_pal_t;

endpackage

`default_nettype wire

//--- rtl/lcd_pxl_pkg.sv
/* pixel path types */
`default_nettype none

package lcd_pxl_pkg;

    // scroll pixel, idx 0 is transparent
    typedef struct packed {
        logic [3:0] col;        // palette number
        logic [1:0] idx;        // color index
    } lyr_pxl_t;

    // object pixel, scroll fields plus priority
    typedef struct packed {
        lyr_pxl_t   pxl;
        logic [1:0] prio;       // 0 hidden, 1 back, 2 middle, 3 front
    } obj_pxl_t;

    // winning layer, also the top bits of both palette addresses
    typedef enum logic [1:0] {
        LYR_SCR1 = 2'd0,
        LYR_SCR2 = 2'd1,
        LYR_OBJ  = 2'd2,
        LYR_BACK = 2'd3
    } lyr_e;

    // registered output of the priority stage
    typedef struct packed {
        logic [7:0] addr;       // color table address
        logic [4:0] mono_addr;  // shade table address
        logic       mono;       // monochrome mode
        logic       blank;      // outside active display
    } mix_pxl_t;

    // color table entry, red in the low nibble
    typedef struct packed {
        logic [3:0] b;
        logic [3:0] g;
        logic [3:0] r;
    } rgb_t;

    typedef logic [3:0] shade_t;    // grey level

endpackage

`default_nettype wire
